/* all.f */
rtl/hyp_pkg.sv
rtl/hyp_cfg_regs.sv
rtl/hyp_ctrl.sv
rtl/hyp_pad_io.sv
rtl/hyp_subsystem.sv
verification/tb_clk_gen.sv
verification/hyp_mem_model.sv
verification/tb_hyp_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_hyp_subsystem
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_hyp_subsystem.sv */
// Table-driven run on one memory model; latency values in the table must stay between 2 and 15
`timescale 1ns/1ps

module tb_hyp_subsystem;

    localparam int                StartupCycles  = 8;
    localparam hyp_pkg::hyp_lat_t DefaultLatency = 4'd6;
    localparam int                MaxLatency     = 15;

    localparam int OP_REG_WR = 0;
    localparam int OP_REG_RD = 1;
    localparam int OP_MEM_WR = 2;
    localparam int OP_MEM_RD = 3;

    logic                   clk;
    logic                   rst_n;
    logic                   req;
    logic                   req_we;
    hyp_pkg::hyp_addr_t     req_addr;
    hyp_pkg::hyp_data_t     req_wdata;
    logic                   busy;
    logic                   rsp_valid;
    hyp_pkg::hyp_data_t     rsp_rdata;
    logic                   reg_valid;
    logic                   reg_we;
    hyp_pkg::hyp_reg_addr_t reg_addr;
    hyp_pkg::hyp_data_t     reg_wdata;
    hyp_pkg::hyp_data_t     reg_rdata;
    logic                   hyper_cs_n;
    logic                   hyper_ck;
    logic                   hyper_reset_n;
    wire  [7:0]             hyper_dq;
    wire                    hyper_rwds;

    int                 kind_q[$];
    hyp_pkg::hyp_addr_t addr_q[$];
    hyp_pkg::hyp_data_t data_q[$];
    hyp_pkg::hyp_data_t exp_q[$];
    string              name_q[$];

    int                pass_count;
    int                fail_count;
    int                cycle_count = 0;
    int                timeout_cycles = 0;
    hyp_pkg::hyp_lat_t cur_lat = DefaultLatency;

    tb_clk_gen #(.PeriodNs(40), .ResetCycles(3)) i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    hyp_subsystem #(
        .DefaultLatency ( DefaultLatency ),
        .StartupCycles  ( StartupCycles  )
    ) i_hyp_subsystem (
        .clk_i          ( clk           ),
        .rst_n_i        ( rst_n         ),
        .req_i          ( req           ),
        .req_we_i       ( req_we        ),
        .req_addr_i     ( req_addr      ),
        .req_wdata_i    ( req_wdata     ),
        .busy_o         ( busy          ),
        .rsp_valid_o    ( rsp_valid     ),
        .rsp_rdata_o    ( rsp_rdata     ),
        .reg_valid_i    ( reg_valid     ),
        .reg_we_i       ( reg_we        ),
        .reg_addr_i     ( reg_addr      ),
        .reg_wdata_i    ( reg_wdata     ),
        .reg_rdata_o    ( reg_rdata     ),
        .hyper_cs_no    ( hyper_cs_n    ),
        .hyper_ck_o     ( hyper_ck      ),
        .hyper_reset_no ( hyper_reset_n ),
        .hyper_dq_io    ( hyper_dq      ),
        .hyper_rwds_io  ( hyper_rwds    )
    );

    hyp_mem_model i_mem_model (
        .clk_i    ( clk           ),
        .reset_ni ( hyper_reset_n ),
        .cs_ni    ( hyper_cs_n    ),
        .lat_i    ( cur_lat       ),
        .dq_io    ( hyper_dq      ),
        .rwds_io  ( hyper_rwds    )
    );

    task automatic check_value(input string name, input hyp_pkg::hyp_data_t expected,
                               input hyp_pkg::hyp_data_t actual);
        if (expected === actual) begin
            $display("PASS %s", name);
            pass_count++;
        end else begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            fail_count++;
        end
    endtask

    task automatic add_test(input int kind, input hyp_pkg::hyp_addr_t addr,
                            input hyp_pkg::hyp_data_t data, input hyp_pkg::hyp_data_t expected,
                            input string name);
        kind_q.push_back(kind);
        addr_q.push_back(addr);
        data_q.push_back(data);
        exp_q.push_back(expected);
        name_q.push_back(name);
    endtask

    // Memory write expectations come from the bus timing, so their table value is unused
    task automatic build_table();
        add_test(OP_REG_RD, 24'h0, 32'h0, 32'd6, "lat_default");
        add_test(OP_REG_WR, 24'h0, 32'd5, 32'd5, "lat_write_5");
        add_test(OP_REG_RD, 24'h3, 32'h0, 32'h0, "unmapped_read_3");
        add_test(OP_REG_WR, 24'h7, 32'hffffffff, 32'h0, "unmapped_write_7");
        add_test(OP_REG_RD, 24'h2, 32'h0, 32'd0, "status_initial");
        add_test(OP_MEM_WR, 24'h000010, 32'h12345678, 32'h0, "wr_a0");
        add_test(OP_MEM_WR, 24'h0a5a5a, 32'hcafef00d, 32'h0, "wr_a1");
        add_test(OP_MEM_WR, 24'hffffff, 32'h89abcdef, 32'h0, "wr_a2");
        add_test(OP_MEM_RD, 24'h000010, 32'h0, 32'h12345678, "rd_a0");
        add_test(OP_MEM_RD, 24'h0a5a5a, 32'h0, 32'hcafef00d, "rd_a1");
        add_test(OP_MEM_RD, 24'hffffff, 32'h0, 32'h89abcdef, "rd_a2");
        add_test(OP_REG_RD, 24'h2, 32'h0, 32'd6, "status_after_six");
        add_test(OP_REG_WR, 24'h2, 32'h0, 32'd0, "status_clear");
        add_test(OP_REG_WR, 24'h0, 32'd3, 32'd3, "lat_write_3");
        add_test(OP_MEM_WR, 24'h000020, 32'ha5a55a5a, 32'h0, "wr_lat3");
        add_test(OP_MEM_RD, 24'h000020, 32'h0, 32'ha5a55a5a, "rd_lat3_new");
        add_test(OP_MEM_RD, 24'h000010, 32'h0, 32'h12345678, "rd_lat3_old");
        add_test(OP_REG_WR, 24'h0, 32'd9, 32'd9, "lat_write_9");
        add_test(OP_MEM_WR, 24'h800001, 32'hdeadbeef, 32'h0, "wr_lat9_a");
        add_test(OP_MEM_WR, 24'h000020, 32'h11223344, 32'h0, "wr_lat9_overwrite");
        add_test(OP_MEM_RD, 24'h800001, 32'h0, 32'hdeadbeef, "rd_lat9_a");
        add_test(OP_MEM_RD, 24'h000020, 32'h0, 32'h11223344, "rd_lat9_overwrite");
        add_test(OP_REG_RD, 24'h2, 32'h0, 32'd7, "status_after_clear");
        add_test(OP_REG_WR, 24'h1, 32'h0, 32'd0, "mem_reset_assert");
        add_test(OP_REG_WR, 24'h1, 32'h1, 32'd1, "mem_reset_release");
        add_test(OP_MEM_RD, 24'h0a5a5a, 32'h0, 32'hcafef00d, "rd_after_mem_reset");
    endtask

    task automatic check_reset();
        int startup_count;
        startup_count = 0;
        @(negedge clk);
        check_value("reset_cs_high", 32'd1, {31'd0, hyper_cs_n});
        check_value("reset_ck_low", 32'd0, {31'd0, hyper_ck});
        check_value("reset_rsp_valid_low", 32'd0, {31'd0, rsp_valid});
        check_value("reset_mem_reset_low", 32'd0, {31'd0, hyper_reset_n});
        check_value("reset_busy_high", 32'd1, {31'd0, busy});
        while (!rst_n) @(negedge clk);
        while (busy) begin
            startup_count++;
            @(negedge clk);
        end
        check_value("startup_cycles", 32'(StartupCycles), 32'(startup_count));
        check_value("mem_reset_released", 32'd1, {31'd0, hyper_reset_n});
    endtask

    task automatic apply_entry(input int idx);
        int                 kind;
        hyp_pkg::hyp_addr_t addr;
        hyp_pkg::hyp_data_t data;
        hyp_pkg::hyp_data_t actual;
        int                 cs_low;
        int                 ck_bad;
        logic               prev_ck;
        logic               got_rsp;
        logic               idle;
        kind    = kind_q[idx];
        addr    = addr_q[idx];
        data    = data_q[idx];
        actual  = '0;
        cs_low  = 0;
        ck_bad  = 0;
        prev_ck = 1'b0;
        got_rsp = 1'b0;
        idle    = 1'b0;
        @(posedge clk);
        if (kind == OP_REG_WR || kind == OP_REG_RD) begin
            reg_valid <= 1'b1;
            reg_we    <= (kind == OP_REG_WR);
            reg_addr  <= addr[3:0];
            reg_wdata <= data;
        end else begin
            req       <= 1'b1;
            req_we    <= (kind == OP_MEM_WR);
            req_addr  <= addr;
            req_wdata <= data;
        end
        @(posedge clk);
        reg_valid <= 1'b0;
        reg_we    <= 1'b0;
        req       <= 1'b0;
        if (kind == OP_REG_WR && addr[3:0] == hyp_pkg::REG_LATENCY) begin
            cur_lat = data[3:0];
        end
        while (!idle) begin
            @(negedge clk);
            if (!hyper_cs_n) begin
                cs_low++;
                // Bus clock flips once per selected cycle
                if (cs_low > 1 && hyper_ck == prev_ck) ck_bad++;
            end else if (hyper_ck) begin
                ck_bad++;
            end
            prev_ck = hyper_ck;
            if (rsp_valid) begin
                got_rsp = 1'b1;
                actual  = rsp_rdata;
            end
            if (!busy) idle = 1'b1;
        end
        if (ck_bad != 0) begin
            $display("ERROR %s: bus clock did not toggle each selected cycle", name_q[idx]);
            fail_count++;
        end
        if (kind == OP_MEM_WR) begin
            // Four command bytes, the latency, then four data bytes
            check_value(name_q[idx], 32'(8 + int'(cur_lat)), 32'(cs_low));
        end else if (kind == OP_MEM_RD && !got_rsp) begin
            $display("ERROR %s: read ended without a response pulse", name_q[idx]);
            fail_count++;
        end else begin
            if (kind == OP_REG_WR && addr[3:0] == hyp_pkg::REG_CTRL) begin
                actual = {31'd0, hyper_reset_n};
            end else if (kind != OP_MEM_RD) begin
                actual = reg_rdata;
            end
            check_value(name_q[idx], exp_q[idx], actual);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_cycles > 0 && cycle_count >= timeout_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        req        <= 1'b0;
        req_we     <= 1'b0;
        req_addr   <= '0;
        req_wdata  <= '0;
        reg_valid  <= 1'b0;
        reg_we     <= 1'b0;
        reg_addr   <= '0;
        reg_wdata  <= '0;
        pass_count = 0;
        fail_count = 0;
        build_table();
        timeout_cycles = kind_q.size() * (30 + MaxLatency) + StartupCycles + 10;
        check_reset();
        for (int i = 0; i < kind_q.size(); i++) begin
            apply_entry(i);
        end
        $display("Tests %0d, passed %0d, failed %0d", pass_count + fail_count, pass_count,
                 fail_count);
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verification/hyp_mem_model.sv */
// One word per transfer on clk_i; lat_i must match the controller latency; reads add 0 to 3 cycles
`timescale 1ns/1ps

module hyp_mem_model (
    input  logic              clk_i,
    input  logic              reset_ni,
    input  logic              cs_ni,
    input  hyp_pkg::hyp_lat_t lat_i,
    inout  wire  [7:0]        dq_io,
    inout  wire               rwds_io
);

    hyp_pkg::hyp_data_t mem [hyp_pkg::hyp_addr_t];
    integer             seed = 32'h2e4d75fe;
    int                 cyc;
    int                 data_start;
    logic               is_read;
    hyp_pkg::hyp_addr_t addr;
    logic [23:0]        ca_shift;
    hyp_pkg::hyp_data_t word;

    logic               dq_oe_q;
    hyp_pkg::hyp_byte_t dq_q;
    logic               rwds_oe_q;
    logic               rwds_q;

    assign dq_io   = dq_oe_q ? dq_q : 8'bz;
    assign rwds_io = rwds_oe_q ? rwds_q : 1'bz;

    // Unwritten words return a pattern built from the full address
    function automatic hyp_pkg::hyp_data_t fetch(input hyp_pkg::hyp_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {8'h5a, a};
    endfunction

    always @(posedge clk_i) begin
        if (!reset_ni || cs_ni) begin
            cyc = 0;
            dq_oe_q   <= 1'b0;
            rwds_oe_q <= 1'b0;
            rwds_q    <= 1'b0;
        end else begin
            if (cyc < 3) begin
                ca_shift = {ca_shift[15:0], dq_io};
            end else if (cyc == 3) begin
                is_read    = ca_shift[23];
                addr       = {ca_shift[15:0], dq_io};
                data_start = 4 + int'(lat_i);
                if (is_read) begin
                    data_start = data_start + ($random(seed) & 3);
                end
                word = fetch(addr);
                // RWDS held low through the read latency
                rwds_oe_q <= is_read;
            end else if (!is_read) begin
                if (cyc >= data_start && cyc < data_start + 4) begin
                    word = {word[23:0], dq_io};
                end
                if (cyc == data_start + 3) begin
                    mem[addr] = word;
                end
            end else begin
                if (cyc >= data_start - 1 && cyc < data_start + 3) begin
                    dq_oe_q <= 1'b1;
                    dq_q    <= word[31:24];
                    rwds_q  <= 1'b1;
                    word = {word[23:0], 8'h00};
                end else if (cyc == data_start + 3) begin
                    dq_oe_q <= 1'b0;
                    rwds_q  <= 1'b0;
                end
            end
            cyc = cyc + 1;
        end
    end

endmodule

/* verification/tb_clk_gen.sv */
// Free-running clock from time zero; reset is released on a rising edge after ResetCycles edges
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PeriodNs    = 40,
    parameter int ResetCycles = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PeriodNs / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

/* rtl/hyp_subsystem.sv */
// Everything runs on clk_i; StartupCycles sets how long the memory reset is held after rst_n_i
`timescale 1ns/1ps

module hyp_subsystem #(
    parameter hyp_pkg::hyp_lat_t DefaultLatency = 4'd6,
    parameter int                StartupCycles  = 64
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // Host word requests
    input  logic                   req_i,
    input  logic                   req_we_i,
    input  hyp_pkg::hyp_addr_t     req_addr_i,
    input  hyp_pkg::hyp_data_t     req_wdata_i,
    output logic                   busy_o,
    output logic                   rsp_valid_o,
    output hyp_pkg::hyp_data_t     rsp_rdata_o,
    // Register port
    input  logic                   reg_valid_i,
    input  logic                   reg_we_i,
    input  hyp_pkg::hyp_reg_addr_t reg_addr_i,
    input  hyp_pkg::hyp_data_t     reg_wdata_i,
    output hyp_pkg::hyp_data_t     reg_rdata_o,
    // Memory pins
    output logic                   hyper_cs_no,
    output logic                   hyper_ck_o,
    output logic                   hyper_reset_no,
    inout  wire  [7:0]             hyper_dq_io,
    inout  wire                    hyper_rwds_io
);

    hyp_pkg::hyp_lat_t  latency;
    logic               mem_rst_n;
    logic               done;
    logic               cs_n;
    logic               ck;
    hyp_pkg::hyp_byte_t dq_out;
    logic               dq_oe;
    logic               rwds_out;
    logic               rwds_oe;
    hyp_pkg::hyp_byte_t dq_in;
    logic               rwds_in;

    hyp_cfg_regs #(
        .DefaultLatency ( DefaultLatency )
    ) i_cfg_regs (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .reg_valid_i ( reg_valid_i ),
        .reg_we_i    ( reg_we_i    ),
        .reg_addr_i  ( reg_addr_i  ),
        .reg_wdata_i ( reg_wdata_i ),
        .reg_rdata_o ( reg_rdata_o ),
        .done_i      ( done        ),
        .latency_o   ( latency     ),
        .mem_rst_n_o ( mem_rst_n   )
    );

    hyp_ctrl #(
        .StartupCycles ( StartupCycles )
    ) i_ctrl (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .req_i          ( req_i          ),
        .req_we_i       ( req_we_i       ),
        .req_addr_i     ( req_addr_i     ),
        .req_wdata_i    ( req_wdata_i    ),
        .busy_o         ( busy_o         ),
        .rsp_valid_o    ( rsp_valid_o    ),
        .rsp_rdata_o    ( rsp_rdata_o    ),
        .latency_i      ( latency        ),
        .mem_rst_n_i    ( mem_rst_n      ),
        .done_o         ( done           ),
        .cs_no          ( cs_n           ),
        .ck_o           ( ck             ),
        .dq_o           ( dq_out         ),
        .dq_oe_o        ( dq_oe          ),
        .rwds_o         ( rwds_out       ),
        .rwds_oe_o      ( rwds_oe        ),
        .dq_i           ( dq_in          ),
        .rwds_i         ( rwds_in        ),
        .hyper_reset_no ( hyper_reset_no )
    );

    hyp_pad_io i_pad_io (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .cs_ni         ( cs_n          ),
        .ck_i          ( ck            ),
        .dq_i          ( dq_out        ),
        .dq_oe_i       ( dq_oe         ),
        .rwds_i        ( rwds_out      ),
        .rwds_oe_i     ( rwds_oe       ),
        .dq_o          ( dq_in         ),
        .rwds_o        ( rwds_in       ),
        .hyper_cs_no   ( hyper_cs_no   ),
        .hyper_ck_o    ( hyper_ck_o    ),
        .hyper_dq_io   ( hyper_dq_io   ),
        .hyper_rwds_io ( hyper_rwds_io )
    );

endmodule

/* rtl/hyp_pad_io.sv */
// Inputs are sampled one cycle after the pins; RWDS relies on a pull-down when released
`timescale 1ns/1ps

module hyp_pad_io (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               cs_ni,
    input  logic               ck_i,
    input  hyp_pkg::hyp_byte_t dq_i,
    input  logic               dq_oe_i,
    input  logic               rwds_i,
    input  logic               rwds_oe_i,
    output hyp_pkg::hyp_byte_t dq_o,
    output logic               rwds_o,
    output logic               hyper_cs_no,
    output logic               hyper_ck_o,
    inout  wire  [7:0]         hyper_dq_io,
    inout  wire                hyper_rwds_io
);

    hyp_pkg::hyp_byte_t dq_q;
    logic               rwds_q;

    // Output-only pins
    assign hyper_cs_no = cs_ni;
    assign hyper_ck_o  = ck_i;

    // Bidirectional pins, released when not enabled
    assign hyper_dq_io   = dq_oe_i ? dq_i : 8'bz;
    assign hyper_rwds_io = rwds_oe_i ? rwds_i : 1'bz;

    pulldown i_rwds_pd (hyper_rwds_io);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rwds_q <= 1'b0;
        end else begin
            rwds_q <= hyper_rwds_io;
        end
    end

    always_ff @(posedge clk_i) begin
        dq_q <= hyper_dq_io;
    end

    assign dq_o   = dq_q;
    assign rwds_o = rwds_q;

    // Controller may only drive DQ inside a selected transfer
    a_dq_oe_in_cs : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        cs_ni |-> !dq_oe_i
    ) else $error("DQ driven while chip select is high");

endmodule

/* rtl/hyp_ctrl.sv */
// Requests are single-cycle strobes taken only while busy_o is low; reads wait without timeout
`timescale 1ns/1ps

module hyp_ctrl #(
    parameter int StartupCycles = 64
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               req_i,
    input  logic               req_we_i,
    input  hyp_pkg::hyp_addr_t req_addr_i,
    input  hyp_pkg::hyp_data_t req_wdata_i,
    output logic               busy_o,
    output logic               rsp_valid_o,
    output hyp_pkg::hyp_data_t rsp_rdata_o,
    input  hyp_pkg::hyp_lat_t  latency_i,
    input  logic               mem_rst_n_i,
    output logic               done_o,
    output logic               cs_no,
    output logic               ck_o,
    output hyp_pkg::hyp_byte_t dq_o,
    output logic               dq_oe_o,
    output logic               rwds_o,
    output logic               rwds_oe_o,
    input  hyp_pkg::hyp_byte_t dq_i,
    input  logic               rwds_i,
    output logic               hyper_reset_no
);

    localparam int unsigned StCntW = (StartupCycles > 1) ? $clog2(StartupCycles) : 1;
    localparam logic [StCntW-1:0] StLast = StCntW'(StartupCycles - 1);
    localparam logic [1:0] CaLast   = 2'(hyp_pkg::CA_BYTES - 1);
    localparam logic [1:0] DataLast = 2'(hyp_pkg::DATA_BYTES - 1);

    hyp_pkg::hyp_state_e state_q;
    logic [1:0]          byte_cnt_q;
    hyp_pkg::hyp_lat_t   lat_cnt_q;
    logic [StCntW-1:0]   st_cnt_q;
    logic                we_q;
    logic                ck_q;
    logic                rsp_valid_q;

    hyp_pkg::hyp_data_t  tx_q;
    hyp_pkg::hyp_data_t  wdata_q;
    logic [23:0]         rx_q;
    hyp_pkg::hyp_data_t  rsp_rdata_q;

    logic bus_active;
    logic lat_done;
    logic rd_accept;

    assign bus_active = (state_q == hyp_pkg::CMD) || (state_q == hyp_pkg::LATENCY) ||
                        (state_q == hyp_pkg::WDATA) || (state_q == hyp_pkg::RDATA);
    assign lat_done   = (state_q == hyp_pkg::LATENCY) && (lat_cnt_q == '0);
    // Captured byte counts only when the device flags it valid
    assign rd_accept  = (state_q == hyp_pkg::RDATA) && rwds_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= hyp_pkg::STARTUP;
            byte_cnt_q  <= '0;
            lat_cnt_q   <= '0;
            st_cnt_q    <= '0;
            we_q        <= 1'b0;
            ck_q        <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            ck_q        <= bus_active ? ~ck_q : 1'b0;
            case (state_q)
                hyp_pkg::STARTUP: begin
                    if (st_cnt_q == StLast) begin
                        state_q <= hyp_pkg::IDLE;
                    end else begin
                        st_cnt_q <= st_cnt_q + 1'b1;
                    end
                end
                hyp_pkg::IDLE: begin
                    if (req_i) begin
                        state_q    <= hyp_pkg::CMD;
                        we_q       <= req_we_i;
                        byte_cnt_q <= '0;
                    end
                end
                hyp_pkg::CMD: begin
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                    if (byte_cnt_q == CaLast) begin
                        state_q   <= hyp_pkg::LATENCY;
                        lat_cnt_q <= latency_i - hyp_pkg::hyp_lat_t'(1);
                    end
                end
                hyp_pkg::LATENCY: begin
                    if (lat_done) begin
                        state_q    <= we_q ? hyp_pkg::WDATA : hyp_pkg::RDATA;
                        byte_cnt_q <= '0;
                    end else begin
                        lat_cnt_q <= lat_cnt_q - hyp_pkg::hyp_lat_t'(1);
                    end
                end
                hyp_pkg::WDATA: begin
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                    if (byte_cnt_q == DataLast) begin
                        state_q <= hyp_pkg::GAP;
                    end
                end
                hyp_pkg::RDATA: begin
                    if (rd_accept) begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                        if (byte_cnt_q == DataLast) begin
                            state_q     <= hyp_pkg::GAP;
                            rsp_valid_q <= 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= hyp_pkg::IDLE;
                end
            endcase
        end
    end

    // Shift registers for outgoing and incoming bytes
    always_ff @(posedge clk_i) begin
        if ((state_q == hyp_pkg::IDLE) && req_i) begin
            tx_q    <= {req_we_i ? 8'h00 : 8'h80, req_addr_i};
            wdata_q <= req_wdata_i;
        end else if (lat_done) begin
            tx_q <= wdata_q;
        end else if ((state_q == hyp_pkg::CMD) || (state_q == hyp_pkg::WDATA)) begin
            tx_q <= {tx_q[23:0], 8'h00};
        end
        if (rd_accept) begin
            rx_q <= {rx_q[15:0], dq_i};
            if (byte_cnt_q == DataLast) begin
                rsp_rdata_q <= {rx_q, dq_i};
            end
        end
    end

    assign busy_o      = (state_q != hyp_pkg::IDLE);
    assign rsp_valid_o = rsp_valid_q;
    assign rsp_rdata_o = rsp_rdata_q;
    assign done_o      = (state_q == hyp_pkg::GAP);

    assign cs_no     = ~bus_active;
    assign ck_o      = ck_q && bus_active;
    assign dq_o      = tx_q[31:24];
    assign dq_oe_o   = (state_q == hyp_pkg::CMD) || (state_q == hyp_pkg::WDATA);
    // No byte masking, every written byte is enabled
    assign rwds_o    = 1'b0;
    assign rwds_oe_o = (state_q == hyp_pkg::WDATA);

    assign hyper_reset_no = (state_q != hyp_pkg::STARTUP) && mem_rst_n_i;

    a_no_req_when_busy : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        busy_o |-> !req_i
    ) else $error("req_i pulsed while busy, request dropped");

    // Bytes seen in RDATA were captured a cycle earlier, so DQ must already be released then
    a_no_drive_in_rdata : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (state_q == hyp_pkg::RDATA) |-> !$past(dq_oe_o)
    ) else $error("DQ driven during read data phase");

endmodule

/* rtl/hyp_cfg_regs.sv */
// Register reads are combinational from reg_addr_i; latency values below 2 are illegal
`timescale 1ns/1ps

module hyp_cfg_regs #(
    parameter hyp_pkg::hyp_lat_t DefaultLatency = 4'd6
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   reg_valid_i,
    input  logic                   reg_we_i,
    input  hyp_pkg::hyp_reg_addr_t reg_addr_i,
    input  hyp_pkg::hyp_data_t     reg_wdata_i,
    output hyp_pkg::hyp_data_t     reg_rdata_o,
    input  logic                   done_i,
    output hyp_pkg::hyp_lat_t      latency_o,
    output logic                   mem_rst_n_o
);

    hyp_pkg::hyp_lat_t latency_q;
    logic              mem_rst_n_q;
    hyp_pkg::hyp_cnt_t done_cnt_q;

    logic wr_latency;
    logic wr_ctrl;
    logic wr_status;

    assign wr_latency = reg_valid_i && reg_we_i && (reg_addr_i == hyp_pkg::REG_LATENCY);
    assign wr_ctrl    = reg_valid_i && reg_we_i && (reg_addr_i == hyp_pkg::REG_CTRL);
    assign wr_status  = reg_valid_i && reg_we_i && (reg_addr_i == hyp_pkg::REG_STATUS);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            latency_q   <= DefaultLatency;
            mem_rst_n_q <= 1'b1;
            done_cnt_q  <= '0;
        end else begin
            if (wr_latency) begin
                latency_q <= reg_wdata_i[3:0];
            end
            if (wr_ctrl) begin
                mem_rst_n_q <= reg_wdata_i[0];
            end
            // Clear has priority over a coincident done pulse
            if (wr_status) begin
                done_cnt_q <= '0;
            end else if (done_i) begin
                done_cnt_q <= done_cnt_q + hyp_pkg::hyp_cnt_t'(1);
            end
        end
    end

    always_comb begin
        case (reg_addr_i)
            hyp_pkg::REG_LATENCY: reg_rdata_o = {28'd0, latency_q};
            hyp_pkg::REG_CTRL:    reg_rdata_o = {31'd0, mem_rst_n_q};
            hyp_pkg::REG_STATUS:  reg_rdata_o = {16'd0, done_cnt_q};
            default:              reg_rdata_o = '0;
        endcase
    end

    assign latency_o   = latency_q;
    assign mem_rst_n_o = mem_rst_n_q;

    // Sequencer needs at least two wait cycles for the device turnaround
    a_latency_min : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        wr_latency |-> (reg_wdata_i[3:0] >= 4'd2)
    ) else $error("latency written below 2");

endmodule

/* rtl/hyp_pkg.sv */
// Single chip, one byte per clk_i cycle, 24-bit word address, no bursts and no byte masking
package hyp_pkg;

    // Widths shared by host, register port and bus
    typedef logic [23:0] hyp_addr_t;
    typedef logic [31:0] hyp_data_t;
    typedef logic [7:0]  hyp_byte_t;
    typedef logic [3:0]  hyp_lat_t;
    typedef logic [15:0] hyp_cnt_t;
    typedef logic [3:0]  hyp_reg_addr_t;

    // Register map
    localparam hyp_reg_addr_t REG_LATENCY = 4'd0;
    localparam hyp_reg_addr_t REG_CTRL    = 4'd1;
    localparam hyp_reg_addr_t REG_STATUS  = 4'd2;

    // Bytes per phase of one transfer
    localparam int unsigned CA_BYTES   = 4;
    localparam int unsigned DATA_BYTES = 4;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE,
        STARTUP,
        CMD,
        LATENCY,
        WDATA,
        RDATA,
        GAP
    } hyp_state_e;

endpackage
